// File: sr_consts.svh
// ============================
// Sizing constants for the serial sideband chain
// Frame length, FIFO depth and credit counter width
// ============================

`ifndef SR_CONSTS_SVH
`define SR_CONSTS_SVH

// Serial frame width in bits, kind plus body
`define SR_FRAME_LEN 24

// FIFO entries, also the credits the source starts with
`define SR_FIFO_DEPTH 4

// Credit counter width, holds 0 to SR_FIFO_DEPTH
`define SR_CREDIT_W 3

`endif

// File: sr_frame_pkg.sv
// ============================
// Frame types for the serial chain
// Kind enum, control and data body views,
// body union and the full frame word
// ============================

package sr_frame_pkg;

  `include "sr_consts.svh"

  // Top bit of every frame
  typedef enum logic
  {
    SR_KIND_CTRL = 1'b0,
    SR_KIND_DATA = 1'b1
  } sr_kind_e;

  // Register style access, 3 + 8 + 12 bits
  typedef struct packed
  {
    logic [2:0]  opcode;
    logic [7:0]  addr;
    logic [11:0] cfg_data;
  } sr_ctrl_body_t;

  // Raw payload over the whole body
  typedef struct packed
  {
    logic [`SR_FRAME_LEN-2:0] payload;
  } sr_data_body_t;

  // Same body bits, read as control or as data
  typedef union packed
  {
    sr_ctrl_body_t ctrl;
    sr_data_body_t data;
  } sr_body_u;

  typedef struct packed
  {
    sr_kind_e kind;  // MSB, selects the body view
    sr_body_u body;
  } sr_frame_t;

endpackage

// File: sr_link_pkg.sv
// ============================
// Link control types
// Chain master FSM states and the credit count type
// ============================

package sr_link_pkg;

  `include "sr_consts.svh"

  // Chain master sequencing
  typedef enum logic [1:0]
  {
    SR_MS_IDLE  = 2'd0,  // Waiting for a queued frame
    SR_MS_SHIFT = 2'd1,  // Frame bits on the line
    SR_MS_LOAD  = 2'd2   // Strobe cycle
  } sr_ms_state_e;

  // Credits held by the word source
  typedef logic [`SR_CREDIT_W-1:0] sr_credit_t;

endpackage

// File: sr_word_source.sv
// ============================
// Word source
// Accepts core frames against FIFO credits
// and forwards them as registered pushes
// ============================

`timescale 1ns/1ps

`include "sr_consts.svh"

module sr_word_source
(
  input  logic                    osc_clk,
  input  logic                    reset_n_sync,
  input  logic                    core_valid,
  input  sr_frame_pkg::sr_frame_t core_frame,
  output logic                    core_ready,
  input  logic                    credit_return,
  output logic                    push,
  output sr_frame_pkg::sr_frame_t push_frame
);

  import sr_link_pkg::*;

  sr_credit_t credit_cnt;
  logic       accept;

  assign core_ready = (credit_cnt != '0);       // One free FIFO slot is enough
  assign accept     = core_valid && core_ready;

  // Gains one per return and loses one per accept
  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
      credit_cnt <= sr_credit_t'(`SR_FIFO_DEPTH);
    else
    begin
      case ({credit_return, accept})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
      push <= 1'b0;
    else
      push <= accept;
  end

  always_ff @(posedge osc_clk)
  begin
    if (accept)
      push_frame <= core_frame;  // Held for the FIFO write
  end

  // ============================
  // Credit checks
  // ============================
  a_credit_max: assert property (@(posedge osc_clk) disable iff (!reset_n_sync)
    credit_cnt <= `SR_FIFO_DEPTH)
    else $error("credit count above FIFO depth");

endmodule

// File: sr_frame_fifo.sv
// ============================
// Frame FIFO
// First word fall through circular buffer
// with one credit returned per pop
// ============================

`timescale 1ns/1ps

`include "sr_consts.svh"

module sr_frame_fifo
(
  input  logic                    osc_clk,
  input  logic                    reset_n_sync,
  input  logic                    push,
  input  sr_frame_pkg::sr_frame_t push_frame,
  input  logic                    pop,
  output sr_frame_pkg::sr_frame_t head_frame,
  output logic                    fifo_empty,
  output logic                    credit_return
);

  import sr_frame_pkg::*;

  sr_frame_t                              mem [`SR_FIFO_DEPTH];
  logic [$clog2(`SR_FIFO_DEPTH)-1:0]      wr_ptr;
  logic [$clog2(`SR_FIFO_DEPTH)-1:0]      rd_ptr;
  logic [$clog2(`SR_FIFO_DEPTH + 1)-1:0]  count;
  logic                                   fifo_full;

  // Wraps at the last entry, depth need not be a power of two
  function automatic logic [$clog2(`SR_FIFO_DEPTH)-1:0] next_ptr
  (
    input logic [$clog2(`SR_FIFO_DEPTH)-1:0] ptr
  );
    if (ptr == $bits(ptr)'(`SR_FIFO_DEPTH - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign head_frame = mem[rd_ptr];  // Valid whenever not empty
  assign fifo_empty = (count == '0);
  assign fifo_full  = (count == $bits(count)'(`SR_FIFO_DEPTH));

  always_ff @(posedge osc_clk)
  begin
    if (push)
      mem[wr_ptr] <= push_frame;
  end

  // ============================
  // Pointers and occupancy
  // ============================
  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_return <= pop;  // Slot freed, hand it back
    end
  end

  a_no_overflow: assert property (@(posedge osc_clk) disable iff (!reset_n_sync)
    push |-> !fifo_full)
    else $error("push into full FIFO");

  a_no_underflow: assert property (@(posedge osc_clk) disable iff (!reset_n_sync)
    pop |-> !fifo_empty)
    else $error("pop from empty FIFO");

endmodule

// File: sr_chain_master.sv
// ============================
// Chain master
// Pops frames from the FIFO, shifts them out MSB first
// and closes each frame with a one cycle load strobe
// ============================

`timescale 1ns/1ps

`include "sr_consts.svh"

module sr_chain_master
(
  input  logic                    osc_clk,
  input  logic                    reset_n_sync,
  input  logic                    fifo_empty,
  input  sr_frame_pkg::sr_frame_t head_frame,
  output logic                    pop,
  output logic                    ser_data_out,
  output logic                    ser_load_out
);

  import sr_link_pkg::*;

  sr_ms_state_e                     state_q;
  logic [$clog2(`SR_FRAME_LEN)-1:0] bit_cnt;
  logic [`SR_FRAME_LEN-1:0]         shift_q;  // Outgoing frame
  logic                             last_bit;
  logic                             load_q;

  assign pop      = (state_q == SR_MS_IDLE) && !fifo_empty;
  assign last_bit = (bit_cnt == $bits(bit_cnt)'(`SR_FRAME_LEN - 1));

  // ============================
  // Sequencing
  // ============================
  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      state_q <= SR_MS_IDLE;
      bit_cnt <= '0;
    end
    else
    begin
      case (state_q)
        SR_MS_IDLE:
        begin
          bit_cnt <= '0;
          if (pop)
            state_q <= SR_MS_SHIFT;
        end
        SR_MS_SHIFT:
        begin
          if (last_bit)
            state_q <= SR_MS_LOAD;  // All bits on the line
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
        SR_MS_LOAD:
          state_q <= SR_MS_IDLE;    // One idle cycle before the next pop
        default:
          state_q <= SR_MS_IDLE;
      endcase
    end
  end

  // Output shifter, its MSB drives the line
  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
      shift_q <= '0;
    else if (pop)
      shift_q <= head_frame;
    else if (state_q == SR_MS_SHIFT)
      shift_q <= {shift_q[`SR_FRAME_LEN-2:0], 1'b0};  // Zero fill after the LSB
  end

  // Strobe lines up with the load state
  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
      load_q <= 1'b0;
    else
      load_q <= (state_q == SR_MS_SHIFT) && last_bit;
  end

  assign ser_data_out = shift_q[`SR_FRAME_LEN-1];
  assign ser_load_out = load_q;

  a_load_single: assert property (@(posedge osc_clk) disable iff (!reset_n_sync)
    ser_load_out |=> !ser_load_out)
    else $error("load strobe wider than one cycle");

endmodule

// File: sr_chain_capture.sv
// ============================
// Chain capture
// Shifts the serial line in, latches on the load strobe
// and decodes the control or data view of the body
// ============================

`timescale 1ns/1ps

`include "sr_consts.svh"

module sr_chain_capture
(
  input  logic                     osc_clk,
  input  logic                     reset_n_sync,
  input  logic                     ser_data_in,
  input  logic                     ser_load_in,
  output logic                     rx_valid,
  output sr_frame_pkg::sr_kind_e   rx_kind,
  output logic [2:0]               rx_opcode,
  output logic [7:0]               rx_addr,
  output logic [11:0]              rx_cfg_data,
  output logic [`SR_FRAME_LEN-2:0] rx_payload
);

  import sr_frame_pkg::*;

  logic [`SR_FRAME_LEN-1:0] rx_shift_q;  // Receive shifter
  sr_frame_t                cap_q;       // Last complete frame
  logic                     is_ctrl;

  // Hold on load so the strobe cycle does not shift
  always_ff @(posedge osc_clk)
  begin
    if (!ser_load_in)
      rx_shift_q <= {rx_shift_q[`SR_FRAME_LEN-2:0], ser_data_in};
  end

  always_ff @(posedge osc_clk or negedge reset_n_sync)
  begin
    if (!reset_n_sync)
    begin
      cap_q    <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= ser_load_in;  // One pulse per strobe
      if (ser_load_in)
        cap_q <= rx_shift_q;
    end
  end

  // ============================
  // Body decode
  // ============================
  assign rx_kind     = cap_q.kind;
  assign is_ctrl     = (cap_q.kind == SR_KIND_CTRL);
  assign rx_opcode   = is_ctrl ? cap_q.body.ctrl.opcode   : '0;
  assign rx_addr     = is_ctrl ? cap_q.body.ctrl.addr     : '0;
  assign rx_cfg_data = is_ctrl ? cap_q.body.ctrl.cfg_data : '0;
  assign rx_payload  = is_ctrl ? '0 : cap_q.body.data.payload;  // Data view only

endmodule

// File: sr_chain_top.sv
// ============================
// Serial chain top level
// Word source, frame FIFO, chain master and capture
// ============================

`timescale 1ns/1ps

`include "sr_consts.svh"

module sr_chain_top
(
  input  logic                     osc_clk,
  input  logic                     reset_n_sync,
  input  logic                     core_valid,
  input  sr_frame_pkg::sr_frame_t  core_frame,
  output logic                     core_ready,
  output logic                     ser_data_out,
  output logic                     ser_load_out,
  input  logic                     ser_data_in,
  input  logic                     ser_load_in,
  output logic                     rx_valid,
  output sr_frame_pkg::sr_kind_e   rx_kind,
  output logic [2:0]               rx_opcode,
  output logic [7:0]               rx_addr,
  output logic [11:0]              rx_cfg_data,
  output logic [`SR_FRAME_LEN-2:0] rx_payload
);

  import sr_frame_pkg::*;

  logic      push;
  sr_frame_t push_frame;
  logic      pop;
  sr_frame_t head_frame;
  logic      fifo_empty;
  logic      credit_return;

  sr_word_source sr_word_source_i
  (
    .osc_clk       (osc_clk),
    .reset_n_sync  (reset_n_sync),
    .core_valid    (core_valid),
    .core_frame    (core_frame),
    .core_ready    (core_ready),
    .credit_return (credit_return),
    .push          (push),
    .push_frame    (push_frame)
  );

  sr_frame_fifo sr_frame_fifo_i
  (
    .osc_clk       (osc_clk),
    .reset_n_sync  (reset_n_sync),
    .push          (push),
    .push_frame    (push_frame),
    .pop           (pop),
    .head_frame    (head_frame),
    .fifo_empty    (fifo_empty),
    .credit_return (credit_return)
  );

  sr_chain_master sr_chain_master_i
  (
    .osc_clk      (osc_clk),
    .reset_n_sync (reset_n_sync),
    .fifo_empty   (fifo_empty),
    .head_frame   (head_frame),
    .pop          (pop),
    .ser_data_out (ser_data_out),
    .ser_load_out (ser_load_out)
  );

  sr_chain_capture sr_chain_capture_i
  (
    .osc_clk      (osc_clk),
    .reset_n_sync (reset_n_sync),
    .ser_data_in  (ser_data_in),
    .ser_load_in  (ser_load_in),
    .rx_valid     (rx_valid),
    .rx_kind      (rx_kind),
    .rx_opcode    (rx_opcode),
    .rx_addr      (rx_addr),
    .rx_cfg_data  (rx_cfg_data),
    .rx_payload   (rx_payload)
  );

endmodule

// File: tb_sr_chain.sv
// ============================
// Testbench for the serial sideband chain
// Loopback, reference model, compare process,
// credit and load strobe monitors, timeouts
// ============================

`timescale 1ns/1ps

`include "sr_consts.svh"

module tb_sr_chain;

  import sr_frame_pkg::*;

  localparam int SEND_LIMIT  = 500;
  localparam int DRAIN_LIMIT = 2000;
  localparam int LOAD_PERIOD = `SR_FRAME_LEN + 2;

  logic osc_clk, reset_n_sync, core_valid, core_ready;
  sr_frame_t core_frame;
  logic ser_data, ser_load, rx_valid;
  sr_kind_e rx_kind;
  logic [2:0] rx_opcode;
  logic [7:0] rx_addr;
  logic [11:0] rx_cfg_data;
  logic [`SR_FRAME_LEN-2:0] rx_payload;

  sr_frame_t expected_q [$];  // Accepted and not yet received
  int errors, checks, rx_count, burst_pulses, cycle_cnt, last_pulse_cycle, credits;
  logic burst_active, stall_seen, prev_load;

  sr_chain_top sr_chain_top_i
  (
    .osc_clk(osc_clk), .reset_n_sync(reset_n_sync), .core_valid(core_valid),
    .core_frame(core_frame), .core_ready(core_ready),
    .ser_data_out(ser_data), .ser_load_out(ser_load),  // Looped back below
    .ser_data_in(ser_data), .ser_load_in(ser_load),
    .rx_valid(rx_valid), .rx_kind(rx_kind), .rx_opcode(rx_opcode), .rx_addr(rx_addr),
    .rx_cfg_data(rx_cfg_data), .rx_payload(rx_payload)
  );

  initial
  begin
    osc_clk = 1'b0;
    forever #50 osc_clk = ~osc_clk;
  end

  always @(posedge osc_clk) cycle_cnt++;

  // Expected rx fields where the kind bit picks the view
  function automatic void expected_rx(input sr_frame_t f, output logic kind,
    output logic [2:0] op, output logic [7:0] addr, output logic [11:0] cfg,
    output logic [`SR_FRAME_LEN-2:0] payload);
    logic [`SR_FRAME_LEN-1:0] raw;
    raw = f;
    kind = raw[`SR_FRAME_LEN-1];
    op = kind ? 3'd0 : raw[22:20];
    addr = kind ? 8'd0 : raw[19:12];
    cfg = kind ? 12'd0 : raw[11:0];
    payload = kind ? raw[`SR_FRAME_LEN-2:0] : '0;
  endfunction

  function automatic sr_frame_t make_frame(input logic kind);
    logic [`SR_FRAME_LEN-1:0] raw;
    raw = `SR_FRAME_LEN'($urandom());
    raw[`SR_FRAME_LEN-1] = kind;  // Kind in the top bit
    return sr_frame_t'(raw);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
    input logic [31:0] expected);
    checks++;
    if (actual !== expected)
    begin
      $display("ERROR %0t %s: got 0x%0h expected 0x%0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, frames received: %0d", checks, errors, rx_count);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    errors++;
    finish_run();
  endtask

  // Returns once the frame is sure to be taken at the next edge
  task automatic send_frame(input sr_frame_t f);
    int waited;
    waited = 0;
    @(posedge osc_clk);
    core_valid <= 1'b1;
    core_frame <= f;
    @(negedge osc_clk);
    while (!core_ready)
    begin
      if (waited == SEND_LIMIT)
        report_timeout("core_ready never rose for a pending frame");
      waited++;
      @(negedge osc_clk);
    end
    expected_q.push_back(f);
  endtask

  task automatic release_valid();
    @(posedge osc_clk);
    core_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0)
    begin
      if (waited == DRAIN_LIMIT)
        report_timeout("sent frames did not all come back");
      waited++;
      @(negedge osc_clk);
    end
  endtask

  // ============================
  // Monitors and compare process
  // ============================
  always @(negedge osc_clk)
  begin
    if (!reset_n_sync)
      credits = `SR_FIFO_DEPTH;
    else
    begin
      check_value("core_ready", core_ready, credits != 0);  // Ready while credits remain
      if (burst_active && core_valid && !core_ready)
        stall_seen = 1'b1;
      credits = credits - (core_valid && core_ready) + sr_chain_top_i.credit_return;
    end
  end

  always @(negedge osc_clk)
  begin
    if (reset_n_sync && ser_load && prev_load)
    begin
      $display("ERROR %0t: ser_load_out stayed high for two cycles", $time);
      errors++;
    end
    if (reset_n_sync && ser_load && !prev_load && burst_active)
    begin
      if (burst_pulses > 0)
        check_value("load_gap", cycle_cnt - last_pulse_cycle, LOAD_PERIOD);
      burst_pulses++;
      last_pulse_cycle = cycle_cnt;
    end
    prev_load = ser_load;
  end

  always @(negedge osc_clk)
  begin
    sr_frame_t f;
    logic kind;
    logic [2:0] op;
    logic [7:0] addr;
    logic [11:0] cfg;
    logic [`SR_FRAME_LEN-2:0] payload;
    if (reset_n_sync && rx_valid)
    begin
      if (expected_q.size() == 0)
      begin
        $display("ERROR %0t: rx_valid with no frame outstanding", $time);
        errors++;
      end
      else
      begin
        f = expected_q.pop_front();  // In order delivery
        expected_rx(f, kind, op, addr, cfg, payload);
        check_value("rx_kind", rx_kind, kind);
        check_value("rx_opcode", rx_opcode, op);
        check_value("rx_addr", rx_addr, addr);
        check_value("rx_cfg_data", rx_cfg_data, cfg);
        check_value("rx_payload", rx_payload, payload);
        rx_count++;
      end
    end
  end

  // ============================
  // Stimulus
  // ============================
  initial
  begin
    int i;
    void'($urandom(32'h9b02));
    reset_n_sync = 1'b0;
    core_valid = 1'b0;
    core_frame = '0;
    burst_active = 1'b0;
    stall_seen = 1'b0;
    prev_load = 1'b0;
    repeat (2) @(posedge osc_clk);
    reset_n_sync <= 1'b1;
    for (i = 0; i < 4; i++)
    begin
      @(negedge osc_clk);
      check_value("ser_load_out", ser_load, 1'b0);  // Quiet before the first frame
      check_value("rx_valid", rx_valid, 1'b0);
    end
    for (i = 0; i < 12; i++)
    begin
      send_frame(make_frame(i < 6 ? SR_KIND_DATA : SR_KIND_CTRL));  // Data first
      release_valid();
      wait_drain();
    end
    burst_active = 1'b1;
    for (i = 0; i < 12; i++)
      send_frame(make_frame(1'($urandom_range(1, 0))));  // Valid held high throughout
    release_valid();
    wait_drain();
    burst_active = 1'b0;
    check_value("burst_load_pulses", burst_pulses, 12);
    check_value("core_ready_stall", stall_seen, 1'b1);
    finish_run();
  end

endmodule

// File: verilog.f
+incdir+.
sr_frame_pkg.sv
sr_link_pkg.sv
sr_word_source.sv
sr_frame_fifo.sv
sr_chain_master.sv
sr_chain_capture.sv
sr_chain_top.sv
tb_sr_chain.sv

// File: Bender.yml
package:
  name: sr_chain

sources:
  - include_dirs:
      - .
    files:
      - sr_frame_pkg.sv
      - sr_link_pkg.sv
      - sr_word_source.sv
      - sr_frame_fifo.sv
      - sr_chain_master.sv
      - sr_chain_capture.sv
      - sr_chain_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sr_chain.sv
